//--- verilog/glue_pkg.sv
// glue package: memory map, wait counts, region and cycle-state enums, bus structs
package glue_pkg;

	// ----------------------------------------------------------------------
	// memory map, cpu byte addresses
	// ----------------------------------------------------------------------
	localparam logic [23:0] CHIP_BASE   = 24'h00_0000;	// chip ram, size from config
	localparam logic [23:0] SLOW_BASE   = 24'hC0_0000;	// 512k slow ram
	localparam logic [23:0] ROM_BASE    = 24'hF8_0000;	// 512k kickstart
	localparam logic [23:0] CIA_A_BASE  = 24'hBF_E000;	// 4k window
	localparam logic [23:0] SYSREG_BASE = 24'hDF_F000;	// 16 bytes
	localparam logic [23:0] RTC_BASE    = 24'hDC_0000;	// 64 bytes

	// where slow ram and rom live inside the sram
	localparam logic [23:0] SLOW_RAM_BANK = 24'h20_0000;
	localparam logic [23:0] ROM_RAM_BANK  = 24'h38_0000;

	// extra wait cycles per region
	localparam int WAIT_RAM = 2;
	localparam int WAIT_CIA = 8;
	localparam int WAIT_REG = 0;

	localparam int RESET_FRAMES = 4;	// sof pulses after last reset source
	localparam int LED_CNT_W    = 6;	// led dimming counter width

	// ----------------------------------------------------------------------
	// enums
	// ----------------------------------------------------------------------
	typedef enum logic [2:0] {
		REGION_CHIP,
		REGION_SLOW,
		REGION_ROM,
		REGION_CIA_A,
		REGION_SYSREG,
		REGION_RTC,
		REGION_NONE
	} region_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_DECODE,
		ST_WAIT,
		ST_ACK,
		ST_RELEASE
	} cycle_state_e;

	// ----------------------------------------------------------------------
	// bus structs
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic        as;	// address strobe, active high
		logic        we;	// write cycle
		logic        uds;	// upper byte
		logic        lds;	// lower byte
		logic [22:0] addr;	// word address
		logic [15:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic        rd;
		logic        hwr;
		logic        lwr;
		logic [22:0] addr;	// sram word address
		logic [15:0] wdata;
	} ram_req_t;

	typedef struct packed {
		region_e     region;
		logic [22:0] ram_addr;
		logic        wr_protect;
	} decode_t;

endpackage

//--- verilog/reset_ctrl.sv
// reset sequencer: holds system reset over frame starts, two-flop cpu reset
`timescale 1ns/1ps

module reset_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic rst_ext,
	input  logic usr_reset,
	input  logic sof,
	output logic sys_reset,
	output logic cpu_reset
);
	import glue_pkg::*;

	localparam int CNT_W = $clog2(RESET_FRAMES + 1);

	logic [CNT_W-1:0] frame_cnt;	// frames still to wait
	logic             src;
	logic             cpu_rst_r;	// first sync stage

	assign src = reset || rst_ext || usr_reset;

	always_ff @(posedge clk) begin
		if (src) begin
			frame_cnt <= CNT_W'(RESET_FRAMES);
			sys_reset <= 1'b1;
		end else begin
			if (sof && frame_cnt != '0) frame_cnt <= frame_cnt - 1'b1;
			sys_reset <= frame_cnt != '0;
		end
	end

	// cpu reset trails sys_reset by two clocks
	always_ff @(posedge clk) begin
		if (reset) begin
			cpu_rst_r <= 1'b1;
			cpu_reset <= 1'b1;
		end else begin
			cpu_rst_r <= sys_reset;
			cpu_reset <= cpu_rst_r;
		end
	end

endmodule

//--- verilog/bus_decoder.sv
// address decoder: cpu address to region and sram address, plus kickstart overlay
`timescale 1ns/1ps

module bus_decoder (
	input  logic               clk,
	input  logic               sys_reset,
	input  logic               cpu_reset,
	input  glue_pkg::cpu_req_t req,
	input  logic [2:0]         memory_config,
	input  logic               wr_done,
	output glue_pkg::decode_t  dec
);
	import glue_pkg::*;

	logic [23:0] byte_addr;
	logic        hit_chip;
	logic        hit_slow;
	logic        hit_rom;
	logic        hit_cia_a;
	logic        hit_sysreg;
	logic        hit_rtc;
	logic        ovl;	// kickstart overlay

	assign byte_addr = {req.addr, 1'b0};

	// chip size in 512k units is code+1
	assign hit_chip   = byte_addr[23:19] <= {3'b000, memory_config[1:0]};
	assign hit_slow   = memory_config[2] && (byte_addr[23:19] == SLOW_BASE[23:19]);
	assign hit_rom    = byte_addr[23:19] == ROM_BASE[23:19];
	assign hit_cia_a  = byte_addr[23:12] == CIA_A_BASE[23:12];
	assign hit_sysreg = byte_addr[23:4] == SYSREG_BASE[23:4];
	assign hit_rtc    = byte_addr[23:6] == RTC_BASE[23:6];

	always_comb begin
		dec.region     = REGION_NONE;
		dec.ram_addr   = req.addr;	// chip ram maps 1:1
		dec.wr_protect = 1'b0;
		if (ovl && !req.we && byte_addr[23:19] == CHIP_BASE[23:19]) begin
			// overlay reads of low 512k come from rom
			dec.region     = REGION_ROM;
			dec.ram_addr   = ROM_RAM_BANK[23:1] | {5'd0, req.addr[17:0]};
			dec.wr_protect = 1'b1;
		end else if (hit_chip) begin
			dec.region = REGION_CHIP;
		end else if (hit_slow) begin
			dec.region   = REGION_SLOW;
			dec.ram_addr = SLOW_RAM_BANK[23:1] | {5'd0, req.addr[17:0]};
		end else if (hit_rom) begin
			dec.region     = REGION_ROM;
			dec.ram_addr   = ROM_RAM_BANK[23:1] | {5'd0, req.addr[17:0]};
			dec.wr_protect = 1'b1;	// kickstart is read only
		end else if (hit_cia_a) begin
			dec.region = REGION_CIA_A;
		end else if (hit_sysreg) begin
			dec.region = REGION_SYSREG;
		end else if (hit_rtc) begin
			dec.region = REGION_RTC;
		end
	end

	// overlay set by cpu reset, cleared by any write to cia-a
	always_ff @(posedge clk) begin
		if (sys_reset || cpu_reset) begin
			ovl <= 1'b1;
		end else if (wr_done && hit_cia_a) begin
			ovl <= 1'b0;
		end
	end

endmodule

//--- verilog/bus_cycle.sv
// cpu cycle FSM: decode, region wait states, sram strobes and dtack pulse
`timescale 1ns/1ps

module bus_cycle (
	input  logic                   clk,
	input  logic                   sys_reset,
	input  glue_pkg::cpu_req_t     req,
	input  glue_pkg::decode_t      dec,
	output glue_pkg::ram_req_t     ram,
	output glue_pkg::cycle_state_e state,
	output glue_pkg::region_e      sel_region,
	output logic                   wr_done,
	output logic                   dtack
);
	import glue_pkg::*;

	decode_t     dec_q;	// decode result held for the cycle
	logic [3:0]  wait_cnt;
	logic [3:0]  wait_len;
	logic        mem_cycle;
	logic        in_wait;

	assign sel_region = dec_q.region;

	// wait count of the freshly decoded region
	always_comb begin
		case (dec.region)
			REGION_CHIP, REGION_SLOW, REGION_ROM: wait_len = 4'(WAIT_RAM);
			REGION_CIA_A:                         wait_len = 4'(WAIT_CIA);
			default:                              wait_len = 4'(WAIT_REG);
		endcase
	end

	//----------------------------------------------------------------------
	// state machine
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (sys_reset) begin
			state   <= ST_IDLE;
			dtack   <= 1'b0;
			wr_done <= 1'b0;
		end else begin
			dtack   <= state == ST_ACK;	// one clock pulse
			wr_done <= state == ST_ACK && req.we;
			case (state)
				ST_IDLE:    if (req.as) state <= ST_DECODE;
				ST_DECODE:  state <= ST_WAIT;
				ST_WAIT:    if (wait_cnt == 4'd0) state <= ST_ACK;
				ST_ACK:     state <= ST_RELEASE;
				ST_RELEASE: if (!req.as) state <= ST_IDLE;	// wait for as to drop
				default:    state <= ST_IDLE;
			endcase
		end
	end

	// payload, no reset
	always_ff @(posedge clk) begin
		if (state == ST_DECODE) begin
			dec_q    <= dec;
			wait_cnt <= wait_len;
		end else if (state == ST_WAIT && wait_cnt != 4'd0) begin
			wait_cnt <= wait_cnt - 4'd1;
		end
	end

	//----------------------------------------------------------------------
	// sram port
	//----------------------------------------------------------------------
	assign in_wait   = state == ST_WAIT;
	assign mem_cycle = dec_q.region == REGION_CHIP || dec_q.region == REGION_SLOW ||
			dec_q.region == REGION_ROM;

	assign ram.rd    = in_wait && mem_cycle && !req.we;
	assign ram.hwr   = in_wait && mem_cycle && req.we && req.uds && !dec_q.wr_protect;
	assign ram.lwr   = in_wait && mem_cycle && req.we && req.lds && !dec_q.wr_protect;
	assign ram.addr  = dec_q.ram_addr;
	assign ram.wdata = req.wdata;

endmodule

//--- verilog/read_mux.sv
// read data mux: region-gated sources ORed together, registered for the cpu
`timescale 1ns/1ps

module read_mux (
	input  logic                   clk,
	input  logic                   sys_reset,
	input  glue_pkg::cycle_state_e state,
	input  glue_pkg::region_e      sel_region,
	input  logic [22:0]            addr,
	input  logic [15:0]            ram_rdata,
	input  logic [15:0]            reg_rdata,
	input  logic [63:0]            rtc,
	output logic [15:0]            rdata
);
	import glue_pkg::*;

	logic [15:0] ram_out;
	logic [15:0] reg_out;
	logic [15:0] rtc_out;
	logic        sel_mem;

	assign sel_mem = sel_region == REGION_CHIP || sel_region == REGION_SLOW ||
			sel_region == REGION_ROM;

	assign ram_out = sel_mem ? ram_rdata : 16'h0000;
	assign reg_out = (sel_region == REGION_SYSREG || sel_region == REGION_CIA_A) ?
			reg_rdata : 16'h0000;
	// nibble picked by byte address bits 5:2
	assign rtc_out = (sel_region == REGION_RTC) ?
			{12'h000, rtc[{addr[4:1], 2'b00} +: 4]} : 16'h0000;

	// last wait cycle wins, so the value seen on ack entry is the final sample
	always_ff @(posedge clk) begin
		if (sys_reset) begin
			rdata <= 16'h0000;
		end else if (state == ST_WAIT) begin
			rdata <= ram_out | reg_out | rtc_out;	// unmapped reads as zero
		end
	end

endmodule

//--- verilog/system_regs.sv
// system registers: memory config, ntsc request, user reset, cia-a port and led dimmer
`timescale 1ns/1ps

module system_regs (
	input  logic              clk,
	input  logic              sys_reset,
	input  glue_pkg::region_e sel_region,
	input  logic [22:0]       addr,
	input  logic [15:0]       wdata,
	input  logic              wr_done,
	output logic [15:0]       reg_rdata,
	output logic [2:0]        memory_config,
	output logic              usr_reset,
	output logic              ntsc,
	output logic              pwr_led
);
	import glue_pkg::*;

	logic                 ntsc_req;
	logic [7:0]           porta;	// cia-a port register, bit 1 is led
	logic [LED_CNT_W-1:0] led_cnt;
	logic                 warm = 1'b0;	// user reset in progress, keeps config
	logic                 sys_reset_d = 1'b0;
	logic                 wr_reg;
	logic                 wr_cia;

	assign wr_reg = wr_done && sel_region == REGION_SYSREG;
	assign wr_cia = wr_done && sel_region == REGION_CIA_A;

	// warm flag survives the user reset it triggered
	always_ff @(posedge clk) begin
		sys_reset_d <= sys_reset;
		if (usr_reset) begin
			warm <= 1'b1;
		end else if (sys_reset_d && !sys_reset) begin
			warm <= 1'b0;
		end
	end

	//----------------------------------------------------------------------
	// register writes
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (sys_reset && !warm) begin
			memory_config <= 3'd0;
			ntsc_req      <= 1'b0;
		end else if (wr_reg && addr[2:0] == 3'd0) begin
			memory_config <= wdata[2:0];
			ntsc_req      <= wdata[8];
		end
	end

	always_ff @(posedge clk) begin
		if (sys_reset) begin
			porta     <= 8'h00;
			usr_reset <= 1'b0;
		end else begin
			usr_reset <= wr_reg && addr[2:0] == 3'd1 && wdata[0];	// single pulse
			if (wr_cia) porta <= wdata[7:0];
		end
	end

	// video standard only switches while in reset
	always_ff @(posedge clk) begin
		if (sys_reset) ntsc <= ntsc_req;
	end

	always_comb begin
		reg_rdata = 16'h0000;
		if (sel_region == REGION_CIA_A) begin
			reg_rdata = {8'h00, porta};
		end else if (sel_region == REGION_SYSREG && addr[2:0] == 3'd0) begin
			reg_rdata = {7'd0, ntsc_req, 5'd0, memory_config};
		end
	end

	//----------------------------------------------------------------------
	// power led, dimmed to 4/64 when port bit set
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (sys_reset) led_cnt <= '0;
		else           led_cnt <= led_cnt + 1'b1;
	end

	assign pwr_led = !porta[1] || led_cnt[5:2] == 4'd0;

endmodule

//--- verilog/glue_top.sv
// glue top: wires reset sequencer, decoder, cycle FSM, read mux and system registers
`timescale 1ns/1ps

module glue_top (
	input  logic               clk,
	input  logic               reset,
	input  glue_pkg::cpu_req_t cpu,
	output logic [15:0]        cpu_rdata,
	output logic               dtack,
	output glue_pkg::ram_req_t ram,
	input  logic [15:0]        ram_rdata,
	input  logic               rst_ext,
	input  logic               sof,
	input  logic [63:0]        rtc,
	output logic [2:0]         memcfg,
	output logic               ntsc,
	output logic               pwr_led,
	output logic               cpu_reset,
	output logic               rst_out
);
	import glue_pkg::*;

	logic         sys_reset;
	logic         usr_reset;
	logic         wr_done;	// acknowledged write
	decode_t      dec;
	cycle_state_e state;
	region_e      sel_region;	// region latched for the running cycle
	logic [15:0]  reg_rdata;

	assign rst_out = sys_reset;

	reset_ctrl i_reset_ctrl (
		.clk       (clk),
		.reset     (reset),
		.rst_ext   (rst_ext),
		.usr_reset (usr_reset),
		.sof       (sof),
		.sys_reset (sys_reset),
		.cpu_reset (cpu_reset)
	);

	bus_decoder i_bus_decoder (
		.clk           (clk),
		.sys_reset     (sys_reset),
		.cpu_reset     (cpu_reset),
		.req           (cpu),
		.memory_config (memcfg),
		.wr_done       (wr_done),
		.dec           (dec)
	);

	bus_cycle i_bus_cycle (
		.clk        (clk),
		.sys_reset  (sys_reset),
		.req        (cpu),
		.dec        (dec),
		.ram        (ram),
		.state      (state),
		.sel_region (sel_region),
		.wr_done    (wr_done),
		.dtack      (dtack)
	);

	read_mux i_read_mux (
		.clk        (clk),
		.sys_reset  (sys_reset),
		.state      (state),
		.sel_region (sel_region),
		.addr       (cpu.addr),
		.ram_rdata  (ram_rdata),
		.reg_rdata  (reg_rdata),
		.rtc        (rtc),
		.rdata      (cpu_rdata)
	);

	system_regs i_system_regs (
		.clk           (clk),
		.sys_reset     (sys_reset),
		.sel_region    (sel_region),
		.addr          (cpu.addr),
		.wdata         (cpu.wdata),
		.wr_done       (wr_done),
		.reg_rdata     (reg_rdata),
		.memory_config (memcfg),
		.usr_reset     (usr_reset),
		.ntsc          (ntsc),
		.pwr_led       (pwr_led)
	);

endmodule

//--- testbench/tb_glue.sv
// bus glue testbench: table-driven cpu cycles against an sram model, reset and led checks
`timescale 1ns/1ps

module tb_glue;
	import glue_pkg::*;

	localparam int          SOF_PERIOD = 32;
	localparam int          LAT_RAM    = 5;	// 3 + ram waits
	localparam int          LAT_CIA    = 11;
	localparam int          LAT_REG    = 3;
	localparam logic [20:0] SLOW_WORD  = 21'h10_0000;	// byte 0x200000
	localparam logic [20:0] ROM_WORD   = 21'h1C_0000;	// byte 0x380000
	localparam logic [63:0] RTC_VAL    = 64'h0123_4567_89AB_CDEF;

	typedef struct packed {
		logic        we;
		logic [23:0] addr;	// byte address
		logic [1:0]  be;	// {uds, lds}
		logic [15:0] wdata;
		logic [15:0] rdata_exp;
		logic        chk;	// compare read data
		logic [3:0]  lat_exp;
	} entry_t;

	logic        clk = 1'b0;
	logic        reset;
	cpu_req_t    cpu;
	logic [15:0] cpu_rdata;
	logic        dtack;
	ram_req_t    ram;
	logic [15:0] ram_rdata;
	logic        rst_ext;
	logic        sof = 1'b0;
	logic [63:0] rtc;
	logic [2:0]  memcfg;
	logic        ntsc;
	logic        pwr_led;
	logic        cpu_reset;
	logic        rst_out;

	logic [15:0] mem [0:(1<<21)-1];	// sram words, banks included
	logic [15:0] rom_ref [0:63];	// rom words as preloaded
	logic [31:0] lfsr = 32'h4f54_bf2a;
	entry_t      stim [$];
	int          cycle_cnt = 0;
	int          timeout_cycles = 0;
	int          n_tests = 0;
	int          n_pass = 0;
	int          n_errors = 0;

	glue_top i_glue_top (
		.clk       (clk),
		.reset     (reset),
		.cpu       (cpu),
		.cpu_rdata (cpu_rdata),
		.dtack     (dtack),
		.ram       (ram),
		.ram_rdata (ram_rdata),
		.rst_ext   (rst_ext),
		.sof       (sof),
		.rtc       (rtc),
		.memcfg    (memcfg),
		.ntsc      (ntsc),
		.pwr_led   (pwr_led),
		.cpu_reset (cpu_reset),
		.rst_out   (rst_out)
	);

	always #10 clk = ~clk;	// 20 ns

	// frame start every 32 cycles, plus the watchdog
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		sof       <= cycle_cnt % SOF_PERIOD == SOF_PERIOD - 1;
		if (timeout_cycles != 0 && cycle_cnt >= timeout_cycles) begin
			$display("timeout: run did not finish within %0d cycles", timeout_cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// sram model, read answered combinationally
	// ----------------------------------------------------------------------
	assign ram_rdata = mem[ram.addr[20:0]];

	always @(posedge clk) begin
		if (ram.hwr) mem[ram.addr[20:0]][15:8] <= ram.wdata[15:8];
		if (ram.lwr) mem[ram.addr[20:0]][7:0]  <= ram.wdata[7:0];
	end

	function automatic logic [15:0] fill_word(input logic [20:0] a);
		return a[15:0] ^ {a[4:0], a[20:16], 6'h2b};	// every address bit counts
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// taps 32 22 2 1
	endfunction

	task automatic draw_word(output logic [15:0] w);
		for (int b = 0; b < 16; b++) begin
			lfsr = lfsr_next(lfsr);	// one step per bit
			w[b] = lfsr[0];
		end
	endtask

	function automatic logic [15:0] rtc_nibble(input int k);
		return {12'h000, RTC_VAL[4*k +: 4]};
	endfunction

	task automatic add_rd(input logic [23:0] a, input logic [15:0] d, input int l);
		stim.push_back({1'b0, a, 2'b11, 16'h0000, d, 1'b1, 4'(l)});
	endtask

	task automatic add_wr(input logic [23:0] a, input logic [1:0] be, input logic [15:0] d,
			input int l);
		stim.push_back({1'b1, a, be, d, 16'h0000, 1'b0, 4'(l)});
	endtask

	// one full cpu cycle, latency counted from the edge that sees as
	task automatic cpu_access(input entry_t e, output logic [15:0] d, output int l);
		@(posedge clk);
		cpu.as    <= 1'b1;
		cpu.we    <= e.we;
		cpu.uds   <= e.be[1];
		cpu.lds   <= e.be[0];
		cpu.addr  <= e.addr[23:1];
		cpu.wdata <= e.wdata;
		@(posedge clk);	// idle FSM samples as here
		l = 0;
		@(negedge clk);
		while (!dtack) begin
			@(negedge clk);
			l++;
		end
		d = cpu_rdata;	// valid with dtack
		@(posedge clk);
		cpu.as <= 1'b0;	// address kept, overlay clear needs it
	endtask

	task automatic close_test(input string name, input int errs_at_start);
		n_tests++;
		if (n_errors == errs_at_start) begin
			n_pass++;
			$display("ok   %s", name);
		end else begin
			$display("bad  %s", name);
		end
	endtask

	initial begin
		logic [15:0] rd;
		logic [15:0] f81;
		logic        quiet;
		int          lat;
		int          errs;
		int          sofs;
		int          gap;
		int          on_cnt;
		entry_t      e;

		reset   = 1'b1;
		rst_ext = 1'b0;
		cpu     = '0;
		cpu.as  = 1'b1;	// read pending on the bus while reset is active
		rtc     = RTC_VAL;
		for (int a = 0; a < (1 << 21); a++) mem[a] = fill_word(21'(a));
		for (int k = 0; k < 64; k++) begin
			draw_word(rom_ref[k]);
			mem[ROM_WORD + 21'(k)] = rom_ref[k];
		end
		f81 = fill_word(21'h81);

		// ---- stimulus table, memcfg starts at 0 (512k chip, no slow)
		add_rd(24'h00_0010, rom_ref[8], LAT_RAM);	// overlay on
		add_wr(24'hBF_E001, 2'b11, 16'h00A5, LAT_CIA);	// clears overlay
		add_rd(24'h00_0010, fill_word(21'h8), LAT_RAM);
		add_wr(24'h00_0100, 2'b11, 16'h1234, LAT_RAM);
		add_rd(24'h00_0100, 16'h1234, LAT_RAM);
		add_wr(24'h00_0102, 2'b10, 16'hAB55, LAT_RAM);	// upper byte only
		add_rd(24'h00_0102, {8'hAB, f81[7:0]}, LAT_RAM);
		add_wr(24'h00_0102, 2'b01, 16'h77CD, LAT_RAM);	// lower byte only
		add_rd(24'h00_0102, 16'hABCD, LAT_RAM);
		add_wr(24'h08_0000, 2'b11, 16'hDEAD, LAT_REG);	// past 512k chip
		add_rd(24'h08_0000, 16'h0000, LAT_REG);
		add_wr(24'hC0_0040, 2'b11, 16'hDEAD, LAT_REG);	// slow ram still off
		add_wr(24'hDF_F000, 2'b11, 16'h0105, LAT_REG);	// 1M chip, slow on, ntsc req
		add_rd(24'hDF_F000, 16'h0105, LAT_REG);
		add_rd(24'h08_0000, fill_word(21'h4_0000), LAT_RAM);	// untouched
		add_rd(24'hC0_0040, fill_word(SLOW_WORD + 21'h20), LAT_RAM);
		add_wr(24'hC0_0042, 2'b11, 16'hBEEF, LAT_RAM);
		add_rd(24'hC0_0042, 16'hBEEF, LAT_RAM);
		add_wr(24'hF8_0020, 2'b11, 16'h5555, LAT_RAM);	// rom is read only
		add_rd(24'hF8_0020, rom_ref[16], LAT_RAM);
		add_rd(24'hA0_0000, 16'h0000, LAT_REG);	// unmapped
		add_rd(24'hDC_0000, rtc_nibble(0), LAT_REG);
		add_rd(24'hDC_0014, rtc_nibble(5), LAT_REG);
		add_rd(24'hDC_003C, rtc_nibble(15), LAT_REG);
		add_rd(24'hBF_E000, 16'h00A5, LAT_CIA);	// cia-a port
		timeout_cycles = stim.size() * 16 + 2 * (RESET_FRAMES + 1) * SOF_PERIOD + 4 * 64;

		// ----------------------------------------------------------------------
		// reset sequencing
		// ----------------------------------------------------------------------
		errs = n_errors;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		sofs  = 0;
		quiet = 1'b1;
		@(negedge clk);
		while (rst_out) begin
			if (sof) sofs++;	// dut samples this sof at the next edge
			quiet &= !dtack && !ram.rd && !ram.hwr && !ram.lwr;
			@(posedge clk);
			if (sofs != 0) cpu.as <= 1'b0;	// bus released once frames count
			@(negedge clk);
		end
		gap = 0;
		while (cpu_reset) begin
			quiet &= !dtack && !ram.rd && !ram.hwr && !ram.lwr;
			@(negedge clk);
			gap++;
		end
		assert (sofs == RESET_FRAMES) else begin
			$display("MISMATCH at %0t: rst_out fell after %0d sof, expected %0d",
					$time, sofs, RESET_FRAMES);
			n_errors++;
		end
		assert (gap == 2) else begin
			$display("MISMATCH at %0t: cpu_reset fell %0d cycles after rst_out, expected 2",
					$time, gap);
			n_errors++;
		end
		assert (quiet) else begin
			$display("MISMATCH at %0t: dtack or sram strobe active during reset", $time);
			n_errors++;
		end
		close_test("reset sequencing", errs);

		// ---- table run
		foreach (stim[i]) begin
			e    = stim[i];
			errs = n_errors;
			cpu_access(e, rd, lat);
			assert (lat == int'(e.lat_exp)) else begin
				$display("MISMATCH at %0t: %06h latency %0d, expected %0d",
						$time, e.addr, lat, e.lat_exp);
				n_errors++;
			end
			assert (!e.chk || rd == e.rdata_exp) else begin
				$display("MISMATCH at %0t: %06h read %04h, expected %04h",
						$time, e.addr, rd, e.rdata_exp);
				n_errors++;
			end
			close_test($sformatf("%s %06h", e.we ? "write" : "read ", e.addr), errs);
		end

		// ---- ntsc follows the request only through a user reset
		errs = n_errors;
		assert (memcfg == 3'b101 && !ntsc) else begin
			$display("MISMATCH at %0t: memcfg %0d ntsc %0b before user reset", $time,
					memcfg, ntsc);
			n_errors++;
		end
		e = {1'b1, 24'hDF_F002, 2'b11, 16'h0001, 16'h0000, 1'b0, 4'(LAT_REG)};
		cpu_access(e, rd, lat);
		@(negedge clk);
		while (!rst_out) @(negedge clk);
		while (rst_out) @(negedge clk);
		while (cpu_reset) @(negedge clk);
		assert (ntsc && memcfg == 3'b101) else begin
			$display("MISMATCH at %0t: memcfg %0d ntsc %0b after user reset", $time,
					memcfg, ntsc);
			n_errors++;
		end
		close_test("ntsc after user reset", errs);

		// ----------------------------------------------------------------------
		// power led, full then dimmed
		// ----------------------------------------------------------------------
		errs   = n_errors;
		on_cnt = 0;
		repeat (64) begin
			@(negedge clk);
			if (pwr_led) on_cnt++;
		end
		assert (on_cnt == 64) else begin
			$display("MISMATCH at %0t: led on %0d of 64 cycles, expected 64", $time, on_cnt);
			n_errors++;
		end
		e = {1'b1, 24'hBF_E001, 2'b11, 16'h0002, 16'h0000, 1'b0, 4'(LAT_CIA)};
		cpu_access(e, rd, lat);
		on_cnt = 0;
		repeat (64) begin
			@(negedge clk);
			if (pwr_led) on_cnt++;
		end
		assert (on_cnt == 4) else begin
			$display("MISMATCH at %0t: led on %0d of 64 cycles, expected 4", $time, on_cnt);
			n_errors++;
		end
		close_test("power led dimming", errs);

		$display("tests: %0d run, %0d passed, %0d failed, %0d errors", n_tests, n_pass,
				n_tests - n_pass, n_errors);
		if (n_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- minimig_glue.f
verilog/glue_pkg.sv
verilog/reset_ctrl.sv
verilog/bus_decoder.sv
verilog/bus_cycle.sv
verilog/read_mux.sv
verilog/system_regs.sv
verilog/glue_top.sv
testbench/tb_glue.sv

//--- run_sim.sh
#!/bin/sh
# build the glue testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_glue \
	--Mdir obj_dir -o tb_glue \
	-f minimig_glue.f

out=$(./obj_dir/tb_glue)
echo "$out"

if echo "$out" | grep -qx "PASS: all tests"; then
	exit 0
else
	exit 1
fi
